// File: Bender.yml
package:
  name: ad5676_ctrl

sources:
  - include_dirs:
      - common
    files:
      - common/dac_ctrl_pkg.sv
      - hw/spi_frame_shifter.sv
      - hw/dac_word_pipe.sv
      - sequencer/cmd_sequencer.sv
      - hw/dac_ctrl_top.sv

  - target: test
    include_dirs:
      - common
    files:
      - test/tb_clock_gen.sv
      - test/dac_ctrl_tb.sv

// File: ad5676_ctrl.f
+incdir+common
common/dac_ctrl_pkg.sv
hw/spi_frame_shifter.sv
hw/dac_word_pipe.sv
sequencer/cmd_sequencer.sv
hw/dac_ctrl_top.sv
test/tb_clock_gen.sv
test/dac_ctrl_tb.sv

// File: common/dac_ctrl_macros.svh
`ifndef DAC_CTRL_MACROS_SVH
`define DAC_CTRL_MACROS_SVH

// Channel slot timing
`define DAC_WORD_MIN_TIME   41 // Cycles per channel minus one
`define DAC_SPI_START_DELAY 7  // Slot cycles before the frame starts

// Limits and encodings
`define ABS_CAL_MAX       4096    // Inclusive in both signs
`define SPI_CMD_REG_WRITE 4'b0001 // Write input register, wait for LDAC
`define OFFSET_ZERO       32767   // Code for zero volts
`define DAC_CODE_BAD      16'hFFFF

// Command word fields
`define OPC_HI    31
`define OPC_LO    30
`define TRIG_BIT  29 // Wait for trigger after the command
`define CONT_BIT  28 // Another command must follow
`define LDAC_BIT  27 // Pulse LDAC when the command ends
`define DELAY_W   25 // Delay count in bits 24..0
`define CAL_CH_LO 16 // Channel in 18..16, value in 15..0

`endif

// File: common/dac_ctrl_pkg.sv
package dac_ctrl_pkg;

  // Sequencer states
  typedef enum logic [2:0] {
    S_INIT      = 3'd0, // One cycle after reset
    S_IDLE      = 3'd1, // Waiting for a command word
    S_DELAY     = 3'd2, // Delay count running
    S_TRIG_WAIT = 3'd3, // Waiting for an external trigger
    S_DAC_WR    = 3'd4, // Eight channel slots in progress
    S_ERROR     = 3'd5  // Locked until reset
  } seq_state_e;

  // Command opcodes, bits 31..30 of the command word
  typedef enum logic [1:0] {
    CMD_NO_OP   = 2'b00,
    CMD_DAC_WR  = 2'b01,
    CMD_SET_CAL = 2'b10,
    CMD_CANCEL  = 2'b11  // Ends a delay or trigger wait, no LDAC
  } dac_cmd_e;

  typedef logic        [15:0] dac_code_t; // Offset binary, 32767 is zero volts
  typedef logic signed [15:0] cal_val_t;  // Per-channel signed offset

  // One 24-bit SPI frame, sent MSB first
  typedef struct packed {
    logic [3:0] cmd;     // SPI command nibble
    logic       zero;    // Always 0
    logic [2:0] channel; // DAC channel address
    dac_code_t  code;
  } spi_frame_t;

endpackage

// File: hw/dac_ctrl_top.sv
`timescale 1ns/1ps

module dac_ctrl_top import dac_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cmd_word,
  input  logic        cmd_buf_empty,
  input  logic        trigger,
  output logic        setup_done,
  output logic        cmd_word_rd_en,
  output logic        waiting_for_trigger,
  output logic        cmd_buf_underflow,
  output logic        unexp_trig,
  output logic        cal_oob,
  output logic        dac_val_oob,
  output logic        n_cs,
  output logic        mosi,
  output logic        ldac
);

  logic             in_error;    // Clears pipe and shifter
  logic             dac_start;
  logic             cal_wr;
  logic             word_rd;     // Data word pop request from the pipe
  logic             dac_wr_done;
  logic             frame_load;
  logic             frame_start;
  spi_frame_t [1:0] frame_pair;  // [1] even channel, goes out first

  // Command decode and state
  cmd_sequencer u_seq (
    .clk                 (clk),
    .resetn              (resetn),
    .cmd_word            (cmd_word),
    .cmd_buf_empty       (cmd_buf_empty),
    .trigger             (trigger),
    .word_rd             (word_rd),
    .dac_wr_done         (dac_wr_done),
    .cal_oob             (cal_oob),
    .dac_val_oob         (dac_val_oob),
    .cmd_word_rd_en      (cmd_word_rd_en),
    .in_error            (in_error),
    .dac_start           (dac_start),
    .cal_wr              (cal_wr),
    .waiting_for_trigger (waiting_for_trigger),
    .setup_done          (setup_done),
    .cmd_buf_underflow   (cmd_buf_underflow),
    .unexp_trig          (unexp_trig),
    .ldac                (ldac)
  );

  // Calibration and channel codes
  dac_word_pipe u_pipe (
    .clk           (clk),
    .resetn        (resetn),
    .in_error      (in_error),
    .dac_start     (dac_start),
    .cal_wr        (cal_wr),
    .cmd_word      (cmd_word),
    .cmd_buf_empty (cmd_buf_empty),
    .word_rd       (word_rd),
    .dac_wr_done   (dac_wr_done),
    .cal_oob       (cal_oob),
    .dac_val_oob   (dac_val_oob),
    .frame_load    (frame_load),
    .frame_pair    (frame_pair),
    .frame_start   (frame_start)
  );

  spi_frame_shifter u_spi (
    .clk         (clk),
    .resetn      (resetn),
    .in_error    (in_error),
    .frame_load  (frame_load),
    .frame_pair  (frame_pair),
    .frame_start (frame_start),
    .n_cs        (n_cs),
    .mosi        (mosi)
  );

endmodule

// File: hw/dac_word_pipe.sv
`timescale 1ns/1ps
`include "dac_ctrl_macros.svh"

module dac_word_pipe import dac_ctrl_pkg::*; (
  input  logic             clk,
  input  logic             resetn,
  input  logic             in_error,
  input  logic             dac_start,
  input  logic             cal_wr,
  input  logic [31:0]      cmd_word,
  input  logic             cmd_buf_empty,
  output logic             word_rd,
  output logic             dac_wr_done,
  output logic             cal_oob,
  output logic             dac_val_oob,
  output logic             frame_load,
  output spi_frame_t [1:0] frame_pair,  // [1] even, [0] odd
  output logic             frame_start
);

  localparam logic [5:0] SLOT_LAST  = 6'(`DAC_WORD_MIN_TIME);
  localparam logic [5:0] SPI_START  = 6'(`DAC_WORD_MIN_TIME - `DAC_SPI_START_DELAY);

  cal_val_t           cal_mem [8];
  cal_val_t           cal_in;
  logic               active;      // Channel slots running
  logic [2:0]         chan;
  logic [5:0]         slot_timer;  // Counts down to 0 per slot
  logic               slot_end;
  logic [2:0]         pair_ch;     // Even channel of the word in flight
  logic               valid1;
  logic               valid2;
  logic signed [16:0] sgn_e, sgn_o;   // Offset removed
  logic signed [17:0] sum_e, sum_o;   // Calibration added
  logic               rng_ok;

  // Offset binary to signed, 32767 maps to 0
  function automatic logic signed [16:0] to_signed(dac_code_t c);
    return $signed({1'b0, c}) - 17'(`OFFSET_ZERO);
  endfunction

  function automatic spi_frame_t make_frame(logic [2:0] ch, logic signed [17:0] s);
    spi_frame_t f;
    f.cmd     = `SPI_CMD_REG_WRITE;
    f.zero    = 1'b0;
    f.channel = ch;
    f.code    = 16'(s + 18'(`OFFSET_ZERO)); // Back to offset binary
    return f;
  endfunction

  // Calibration store, values beyond the bound are refused
  assign cal_in = cal_val_t'(cmd_word[15:0]);

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int i = 0; i < 8; i++) cal_mem[i] <= '0;
      cal_oob <= 1'b0;
    end else if (cal_wr) begin
      if (cal_in > `ABS_CAL_MAX || cal_in < -`ABS_CAL_MAX) cal_oob <= 1'b1;
      else cal_mem[cmd_word[`CAL_CH_LO+2:`CAL_CH_LO]] <= cal_in;
    end
  end

  // Slot sequencing, 42 cycles per channel
  assign slot_end = active && slot_timer == '0;

  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      active      <= 1'b0;
      chan        <= '0;
      slot_timer  <= '0;
      dac_wr_done <= 1'b0;
      word_rd     <= 1'b0;
    end else begin
      dac_wr_done <= slot_end && chan == 3'd7;
      word_rd     <= dac_start || (slot_end && chan[0] && chan != 3'd7); // Start of even slot
      if (dac_start) begin
        active     <= 1'b1;
        chan       <= '0;
        slot_timer <= SLOT_LAST;
      end else if (slot_end) begin
        if (chan == 3'd7) active <= 1'b0; // Last slot done
        else begin
          chan       <= chan + 3'd1;
          slot_timer <= SLOT_LAST;
        end
      end else if (active) slot_timer <= slot_timer - 6'd1;
    end
  end

  assign frame_start = active && slot_timer == SPI_START;

  // Stage valids, payload below has no reset
  always_ff @(posedge clk) begin
    if (!resetn || in_error) begin
      valid1     <= 1'b0;
      valid2     <= 1'b0;
      frame_load <= 1'b0;
    end else begin
      valid1     <= word_rd && !cmd_buf_empty
                    && cmd_word[15:0] != `DAC_CODE_BAD && cmd_word[31:16] != `DAC_CODE_BAD;
      valid2     <= valid1;
      frame_load <= valid2 && rng_ok;
    end
  end

  always_ff @(posedge clk) begin
    if (word_rd && !cmd_buf_empty) begin // Load stage
      sgn_e   <= to_signed(cmd_word[15:0]);
      sgn_o   <= to_signed(cmd_word[31:16]);
      pair_ch <= chan;
    end
    sum_e <= sgn_e + cal_mem[pair_ch];        // Calibration stage
    sum_o <= sgn_o + cal_mem[pair_ch + 3'd1];
    if (valid2) frame_pair <= {make_frame(pair_ch, sum_e), make_frame(pair_ch + 3'd1, sum_o)};
  end

  // Result must land in 0..65534 offset binary
  assign rng_ok = sum_e >= -`OFFSET_ZERO && sum_e <= `OFFSET_ZERO
                  && sum_o >= -`OFFSET_ZERO && sum_o <= `OFFSET_ZERO;

  always_ff @(posedge clk) begin
    if (!resetn) dac_val_oob <= 1'b0;
    else if (word_rd && !cmd_buf_empty
             && (cmd_word[15:0] == `DAC_CODE_BAD || cmd_word[31:16] == `DAC_CODE_BAD))
      dac_val_oob <= 1'b1; // Forbidden raw code
    else if (valid2 && !rng_ok) dac_val_oob <= 1'b1;
  end

  a_load_not_on_start: assert property (@(posedge clk) disable iff (!resetn)
    frame_load |-> !frame_start);

endmodule

// File: hw/spi_frame_shifter.sv
`timescale 1ns/1ps

module spi_frame_shifter import dac_ctrl_pkg::*; (
  input  logic             clk,
  input  logic             resetn,
  input  logic             in_error,
  input  logic             frame_load,
  input  spi_frame_t [1:0] frame_pair,
  input  logic             frame_start,
  output logic             n_cs,
  output logic             mosi
);

  localparam int FRAME_BITS = $bits(spi_frame_t);

  logic [47:0] shift_reg;  // Even frame in the upper half
  logic [4:0]  bit_cnt;    // Bits left in the current frame

  always_ff @(posedge clk) begin
    if (!resetn || in_error) bit_cnt <= '0;
    else if (bit_cnt != '0) bit_cnt <= bit_cnt - 5'd1;
    else if (frame_start) bit_cnt <= 5'(FRAME_BITS);
  end

  // Shift on every edge of an active frame, load between frames
  always_ff @(posedge clk) begin
    if (bit_cnt != '0) shift_reg <= {shift_reg[46:0], 1'b0};
    else if (frame_load) shift_reg <= frame_pair;
  end

  // Low for 25 cycles per frame
  always_ff @(posedge clk) begin
    if (!resetn || in_error) n_cs <= 1'b1;
    else if (frame_start) n_cs <= 1'b0;
    else if (bit_cnt == '0) n_cs <= 1'b1;
  end

  assign mosi = shift_reg[47]; // MSB first

  a_cs_low_max: assert property (@(posedge clk) disable iff (!resetn)
    $fell(n_cs) |-> ##[1:25] n_cs);

endmodule

// File: sequencer/cmd_sequencer.sv
`timescale 1ns/1ps
`include "dac_ctrl_macros.svh"

module cmd_sequencer import dac_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        resetn,
  input  logic [31:0] cmd_word,
  input  logic        cmd_buf_empty,
  input  logic        trigger,
  input  logic        word_rd,      // Pipe wants a data word
  input  logic        dac_wr_done,
  input  logic        cal_oob,
  input  logic        dac_val_oob,
  output logic        cmd_word_rd_en,
  output logic        in_error,
  output logic        dac_start,
  output logic        cal_wr,
  output logic        waiting_for_trigger,
  output logic        setup_done,
  output logic        cmd_buf_underflow,
  output logic        unexp_trig,
  output logic        ldac
);

  seq_state_e               state;
  seq_state_e               state_nx;
  seq_state_e               cmd_state;   // State the head command leads to
  dac_cmd_e                 opc;
  logic                     cmd_done;    // Current command has ended
  logic                     next_cmd;    // ... and the next one is popped
  logic                     cancel_wait;
  logic                     err_now;
  logic                     do_ldac;     // Latched command bits
  logic                     wait_trig;
  logic                     expect_next;
  logic [`DELAY_W-1:0]      delay_timer;

  assign opc = dac_cmd_e'(cmd_word[`OPC_HI:`OPC_LO]);

  // Cancel only acts on a running wait
  assign cancel_wait = (state == S_DELAY || state == S_TRIG_WAIT)
                       && !cmd_buf_empty && opc == CMD_CANCEL;

  assign cmd_done = (state == S_IDLE && !cmd_buf_empty)
                    || (state == S_DELAY && delay_timer == '0)
                    || (state == S_TRIG_WAIT && trigger);
  assign next_cmd = cmd_done && !cmd_buf_empty;

  // Any error seen this cycle including the sticky flags
  assign err_now = cal_oob || dac_val_oob || unexp_trig || cmd_buf_underflow
                   || (trigger && state != S_TRIG_WAIT)
                   || (word_rd && cmd_buf_empty);

  always_comb begin
    if (cmd_buf_empty)
      cmd_state = expect_next ? S_ERROR : S_IDLE; // Promised word missing
    else begin
      case (opc)
        CMD_NO_OP:  cmd_state = cmd_word[`TRIG_BIT] ? S_TRIG_WAIT : S_DELAY;
        CMD_DAC_WR: cmd_state = S_DAC_WR;
        default:    cmd_state = S_IDLE; // Set-cal and cancel finish at once
      endcase
    end
  end

  always_comb begin
    state_nx = state;
    if (state == S_INIT) state_nx = S_IDLE;
    else if (err_now) state_nx = S_ERROR;
    else if (cancel_wait) state_nx = S_IDLE;
    else if (cmd_done) state_nx = cmd_state;
    else if (state == S_DAC_WR && dac_wr_done)
      state_nx = wait_trig ? S_TRIG_WAIT : S_DELAY; // Wait phase after the write
  end

  always_ff @(posedge clk) begin
    if (!resetn) state <= S_INIT;
    else state <= state_nx; // S_ERROR has no way out
  end

  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) setup_done <= 1'b0;
    else if (state == S_INIT) setup_done <= 1'b1;
  end

  // Trigger, continue and LDAC bits of the command now running
  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) begin
      do_ldac     <= 1'b0;
      wait_trig   <= 1'b0;
      expect_next <= 1'b0;
    end else if (next_cmd || cancel_wait) begin
      expect_next <= cmd_word[`CONT_BIT];
      if (opc == CMD_NO_OP || opc == CMD_DAC_WR) begin
        do_ldac   <= cmd_word[`LDAC_BIT];
        wait_trig <= cmd_word[`TRIG_BIT];
      end else begin
        do_ldac   <= 1'b0;
        wait_trig <= 1'b0;
      end
    end
  end

  // Delay count only runs in S_DELAY after any DAC write
  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) delay_timer <= '0;
    else if (cancel_wait) delay_timer <= '0;
    else if (next_cmd && (opc == CMD_NO_OP || opc == CMD_DAC_WR) && !cmd_word[`TRIG_BIT])
      delay_timer <= cmd_word[`DELAY_W-1:0];
    else if (state == S_DELAY && delay_timer != '0)
      delay_timer <= delay_timer - 1'b1;
  end

  // No pop in a cycle that ends in error
  assign cmd_word_rd_en = state != S_ERROR && !err_now
                          && (word_rd || next_cmd || cancel_wait);

  assign dac_start = next_cmd && !err_now && opc == CMD_DAC_WR;
  assign cal_wr    = next_cmd && !err_now && opc == CMD_SET_CAL; // Pipe reads cmd_word directly

  assign waiting_for_trigger = (state == S_TRIG_WAIT);
  assign in_error            = (state == S_ERROR);

  // Sticky flags cleared only by reset
  always_ff @(posedge clk) begin
    if (!resetn) unexp_trig <= 1'b0;
    else if (trigger && state != S_TRIG_WAIT) unexp_trig <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (!resetn) cmd_buf_underflow <= 1'b0;
    else if (((cmd_done && expect_next) || word_rd) && cmd_buf_empty)
      cmd_buf_underflow <= 1'b1;
  end

  // LDAC one cycle after the requesting command ends
  // Back-to-back requests merge into one pulse
  always_ff @(posedge clk) begin
    if (!resetn || state == S_ERROR) ldac <= 1'b0;
    else ldac <= do_ldac && cmd_done && !cancel_wait && state != S_IDLE && !ldac;
  end

  a_no_pop_when_empty: assert property (@(posedge clk) disable iff (!resetn)
    cmd_word_rd_en |-> !cmd_buf_empty);

  a_ldac_single: assert property (@(posedge clk) disable iff (!resetn)
    ldac |=> !ldac);

endmodule

// File: test/dac_ctrl_tb.sv
`timescale 1ns/1ps
`include "dac_ctrl_macros.svh"

module dac_ctrl_tb import dac_ctrl_pkg::*; ();

  localparam int NCASE = 8;

  // One row of the case table
  typedef struct packed {
    bit       ldac_b;
    bit       trig_b;
    bit       cont_b;
    int       delay;
    int       cal_kind;   // 0 none, 1 random on all channels, 2 value 5000 on channel 3
    bit       bad_code;   // Raw 16'hFFFF in the first data word
    bit       cancel;     // End the trigger wait with a cancel word
    bit       idle_trig;  // Trigger with no command running
    int       exp_frames;
    int       exp_ldac;
    bit [3:0] exp_err;    // {underflow, unexp_trig, dac_val_oob, cal_oob}
  } tcase_t;

  logic        clk;
  logic        resetn;
  logic        rst_req;
  logic [31:0] cmd_word;
  logic        cmd_buf_empty;
  logic        trigger;
  logic        setup_done;
  logic        cmd_word_rd_en;
  logic        waiting_for_trigger;
  logic        cmd_buf_underflow;
  logic        unexp_trig;
  logic        cal_oob;
  logic        dac_val_oob;
  logic        n_cs;
  logic        mosi;
  logic        ldac;
  logic [3:0]  err_flags;

  tcase_t             cases [NCASE];
  logic [31:0]        data_w [NCASE][4];
  logic signed [15:0] cal_v [NCASE][8];
  logic [31:0]        cmd_q [$];     // Command buffer contents, head first
  logic [23:0]        frames_q [$];  // Frames seen on the SPI pins
  logic [23:0]        cap_frame;
  logic [31:0]        lfsr_state;
  int                 cap_bits;
  int                 ldac_cnt;
  int                 err_cnt;
  int                 frame_cnt;
  int                 cycle_cnt;
  int                 limit;
  int                 cur_case;

  assign err_flags = {cmd_buf_underflow, unexp_trig, dac_val_oob, cal_oob};

  tb_clock_gen u_clk (.rst_req(rst_req), .clk(clk), .resetn(resetn));

  dac_ctrl_top dut (
    .clk                 (clk),
    .resetn              (resetn),
    .cmd_word            (cmd_word),
    .cmd_buf_empty       (cmd_buf_empty),
    .trigger             (trigger),
    .setup_done          (setup_done),
    .cmd_word_rd_en      (cmd_word_rd_en),
    .waiting_for_trigger (waiting_for_trigger),
    .cmd_buf_underflow   (cmd_buf_underflow),
    .unexp_trig          (unexp_trig),
    .cal_oob             (cal_oob),
    .dac_val_oob         (dac_val_oob),
    .n_cs                (n_cs),
    .mosi                (mosi),
    .ldac                (ldac)
  );

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] take_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state); // One step per bit
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  function automatic logic [31:0] dac_header(tcase_t c);
    logic [31:0] w;
    w = '0;
    w[`OPC_HI:`OPC_LO] = CMD_DAC_WR;
    w[`TRIG_BIT]       = c.trig_b;
    w[`CONT_BIT]       = c.cont_b;
    w[`LDAC_BIT]       = c.ldac_b;
    w[`DELAY_W-1:0]    = c.delay[`DELAY_W-1:0];
    return w;
  endfunction

  function automatic logic [31:0] cal_word(int ch, logic signed [15:0] val);
    logic [31:0] w;
    w = '0;
    w[`OPC_HI:`OPC_LO]             = CMD_SET_CAL;
    w[`CAL_CH_LO+2:`CAL_CH_LO]     = ch[2:0];
    w[15:0]                        = val;
    return w;
  endfunction

  task automatic add_case(int k, bit ld, bit tr, bit ct, int dly, int calk, bit bad,
                          bit cn, bit it, int nf, int nl, bit [3:0] er);
    cases[k].ldac_b     = ld;
    cases[k].trig_b     = tr;
    cases[k].cont_b     = ct;
    cases[k].delay      = dly;
    cases[k].cal_kind   = calk;
    cases[k].bad_code   = bad;
    cases[k].cancel     = cn;
    cases[k].idle_trig  = it;
    cases[k].exp_frames = nf;
    cases[k].exp_ldac   = nl;
    cases[k].exp_err    = er;
  endtask

  task automatic build_table();
    int v;
    //       ldac trig cont delay cal bad cancel idle frames ldac flags
    add_case(0, 1, 0, 0, 20, 0, 0, 0, 0, 8, 1, 4'b0000); // Plain write, delay, LDAC
    add_case(1, 1, 0, 0, 10, 1, 0, 0, 0, 8, 1, 4'b0000); // Calibrated write
    add_case(2, 1, 1, 0,  0, 0, 0, 0, 0, 8, 1, 4'b0000); // Trigger ends the wait
    add_case(3, 1, 1, 0,  0, 0, 0, 1, 0, 8, 0, 4'b0000); // Cancel ends the wait
    add_case(4, 1, 0, 0,  0, 2, 0, 0, 0, 0, 0, 4'b0001); // Calibration 5000
    add_case(5, 1, 0, 0,  0, 0, 1, 0, 0, 0, 0, 4'b0010); // Forbidden raw code
    add_case(6, 0, 0, 0,  0, 0, 0, 0, 1, 0, 0, 4'b0100); // Trigger while idle
    add_case(7, 0, 0, 1, 30, 0, 0, 0, 0, 8, 0, 4'b1000); // Missing follow-up word
    for (int k = 0; k < NCASE; k++) begin
      for (int w = 0; w < 4; w++) begin
        data_w[k][w][15:0]  = 16'(4096 + take_bits(16) % 55905); // Even channel
        data_w[k][w][31:16] = 16'(4096 + take_bits(16) % 55905); // Odd channel
      end
      if (cases[k].bad_code) data_w[k][0][15:0] = `DAC_CODE_BAD;
      for (int ch = 0; ch < 8; ch++) begin
        v = take_bits(14) % 8193;
        cal_v[k][ch] = (cases[k].cal_kind == 1) ? 16'(v - `ABS_CAL_MAX) : 16'sd0;
      end
    end
  endtask

  task automatic report_error(string msg);
    err_cnt++;
    $display("ERROR @%0t ns: case %0d: %s", $time, cur_case, msg);
  endtask

  task automatic pulse_trigger();
    @(posedge clk);
    trigger <= 1'b1;
    @(posedge clk);
    trigger <= 1'b0;
  endtask

  task automatic run_case(int k);
    logic [31:0] w;
    logic [15:0] code;
    logic [23:0] exp_f;
    cur_case = k;
    @(posedge clk);
    rst_req <= 1'b1;
    @(posedge clk);
    rst_req <= 1'b0;
    @(negedge clk);
    cmd_q.delete();
    frames_q.delete();
    ldac_cnt = 0;
    while (!resetn || !setup_done) @(negedge clk);
    if (n_cs !== 1'b1) report_error("n_cs not high after reset");
    if (ldac !== 1'b0) report_error("ldac not low after reset");

    // Fill the command buffer
    if (cases[k].cal_kind == 1) begin
      for (int ch = 0; ch < 8; ch++)
        cmd_q.push_back(cal_word(ch, cal_v[k][ch]));
    end else if (cases[k].cal_kind == 2) cmd_q.push_back(cal_word(3, 16'sd5000));
    if (cases[k].idle_trig) pulse_trigger();
    else begin
      cmd_q.push_back(dac_header(cases[k]));
      for (int i = 0; i < 4; i++)
        cmd_q.push_back(data_w[k][i]);
    end

    if (cases[k].trig_b) begin
      while (!waiting_for_trigger) @(negedge clk);
      if (cases[k].cancel) cmd_q.push_back({CMD_CANCEL, 30'h0});
      else pulse_trigger();
    end

    // Wait for the error flag or the end of the command
    if (cases[k].exp_err != 0) begin
      while (err_flags == 4'b0000) @(negedge clk);
    end else begin
      while (ldac_cnt < cases[k].exp_ldac || frames_q.size() < cases[k].exp_frames
             || waiting_for_trigger || cmd_q.size() != 0) @(negedge clk);
    end
    repeat (16) @(negedge clk); // Room for stray pulses or frames

    if (err_flags !== cases[k].exp_err)
      report_error($sformatf("error flags %b, expected %b", err_flags, cases[k].exp_err));
    if (cases[k].exp_err != 0) begin
      if (setup_done !== 1'b0) report_error("setup_done still high after an error");
      if (n_cs !== 1'b1) report_error("n_cs low in the error state");
    end else if (setup_done !== 1'b1) report_error("setup_done dropped");
    if (waiting_for_trigger !== 1'b0) report_error("still waiting for trigger");
    if (ldac_cnt != cases[k].exp_ldac)
      report_error($sformatf("%0d ldac pulses, expected %0d", ldac_cnt, cases[k].exp_ldac));
    if (frames_q.size() != cases[k].exp_frames)
      report_error($sformatf("%0d frames, expected %0d", frames_q.size(), cases[k].exp_frames));
    for (int i = 0; i < frames_q.size() && i < 8; i++) begin
      w     = data_w[k][i / 2];
      code  = ((i % 2) == 0) ? w[15:0] : w[31:16];
      code  = code + cal_v[k][i];                    // Raw plus calibration
      exp_f = {`SPI_CMD_REG_WRITE, 1'b0, 3'(i), code};
      frame_cnt++;
      if (frames_q[i] !== exp_f)
        report_error($sformatf("frame %0d is %h, expected %h", i, frames_q[i], exp_f));
    end
  endtask

  // FWFT command buffer, pops on rd_en
  always @(posedge clk) begin
    if (cmd_word_rd_en && cmd_q.size() > 0) void'(cmd_q.pop_front());
    cmd_buf_empty <= (cmd_q.size() == 0);
    cmd_word      <= (cmd_q.size() > 0) ? cmd_q[0] : 32'h0;
  end

  // SPI capture, first 24 edges with n_cs low
  always @(posedge clk) begin
    if (ldac) ldac_cnt++;
    if (n_cs) cap_bits = 0;
    else if (cap_bits < 24) begin
      cap_frame = {cap_frame[22:0], mosi}; // MSB first
      cap_bits++;
      if (cap_bits == 24) frames_q.push_back(cap_frame);
    end
  end

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= limit) begin
      $display("Timeout: case %0d did not finish within %0d cycles", cur_case, limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  initial begin
    cmd_word      = 32'h0;
    cmd_buf_empty = 1'b1;
    trigger       = 1'b0;
    rst_req       = 1'b0;
    cap_bits      = 0;
    cap_frame     = '0;
    ldac_cnt      = 0;
    err_cnt       = 0;
    frame_cnt     = 0;
    cycle_cnt     = 0;
    cur_case      = 0;
    lfsr_state    = 32'h73ff;
    build_table();
    limit = 200;
    for (int k = 0; k < NCASE; k++) begin
      if (!cases[k].idle_trig) limit += 400; // One DAC write per case
      limit += cases[k].delay;
    end
    for (int k = 0; k < NCASE; k++)
      run_case(k);
    $display("Cases: %0d, frames checked: %0d, errors: %0d", NCASE, frame_cnt, err_cnt);
    if (err_cnt == 0) $display("*** TEST PASSED ***");
    else $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: test/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  input  logic rst_req, // Restarts the 3-cycle reset
  output logic clk,
  output logic resetn
);

  logic [1:0] rst_cnt;  // Reset cycles left

  initial begin
    clk     = 1'b0;
    rst_cnt = 2'd3;     // Power-on reset
  end

  always #2 clk = ~clk; // 4 ns period

  always @(posedge clk) begin
    if (rst_req) rst_cnt <= 2'd3;
    else if (rst_cnt != 2'd0) rst_cnt <= rst_cnt - 2'd1;
  end

  assign resetn = (rst_cnt == 2'd0);

endmodule
